//--- common/lsu_pkg.sv
package lsu_pkg;

    // address map
    localparam logic [31:0] sram_base   = 32'h8000_0000;
    localparam int          sram_words  = 256;
    localparam int          sram_aw     = $clog2(sram_words);
    localparam logic [31:0] sram_limit  = sram_base + 32'(sram_words * 4);
    localparam logic [31:0] serial_addr = 32'ha000_03f8;

    // 2-bit access mask encoding
    typedef enum logic [1:0] {
        sz_none = 2'b00,
        sz_byte = 2'b01,
        sz_half = 2'b10,
        sz_word = 2'b11
    } size_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } resp_e;

    // core request, 68 bits
    typedef struct packed {
        logic        we;
        logic        sign;
        size_e       size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    typedef struct packed {
        logic [31:0] addr;  // word aligned
        logic [31:0] wdata; // lanes already placed
        logic [3:0]  wstrb;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        resp_e       resp;
    } bus_rsp_t;

    // load word seen as bytes or halves
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage

//--- lsu/lsu_core.sv
module lsu_core import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  lsu_req_t req,
    input  logic     arready,
    input  logic     awready,
    input  logic     wready,
    input  logic     rvalid,
    input  logic     bvalid,
    input  bus_rsp_t bus_rsp,
    output logic     arvalid,
    output logic     awvalid,
    output logic     wvalid,
    output logic     rready,
    output logic     bready,
    output bus_req_t bus_req,
    output logic     done,
    output lsu_rsp_t rsp
);

    typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_e;

    state_e      state;
    lsu_req_t    req_q;
    logic [1:0]  off;
    logic [3:0]  wstrb;
    load_word_u  lw;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_data;
    logic        rsp_hs;

    assign off = req_q.addr[1:0];

    always_comb begin
        case (req_q.size)
            sz_byte: wstrb = 4'b0001 << off;
            sz_half: wstrb = off[1] ? 4'b1100 : 4'b0011;
            sz_word: wstrb = 4'b1111;
            default: wstrb = 4'b0000;
        endcase
    end

    assign bus_req = '{
        addr:  {req_q.addr[31:2], 2'b00},
        wdata: req_q.wdata << {off, 3'b000},
        wstrb: req_q.we ? wstrb : 4'b0000  // loads carry no strobe
    };

    assign arvalid = (state == st_addr) && !req_q.we;
    assign awvalid = (state == st_addr) && req_q.we;
    assign wvalid  = (state == st_data);
    assign rready  = (state == st_resp) && !req_q.we;
    assign bready  = (state == st_resp) && req_q.we;
    assign rsp_hs  = (rvalid && rready) || (bvalid && bready);

    // pick the addressed lane, then extend
    assign lw      = bus_rsp.rdata;
    assign ld_byte = lw.bytes[off];
    assign ld_half = lw.halves[off[1]];

    always_comb begin
        case (req_q.size)
            sz_byte: ld_data = {{24{req_q.sign & ld_byte[7]}}, ld_byte};
            sz_half: ld_data = {{16{req_q.sign & ld_half[15]}}, ld_half};
            sz_word: ld_data = lw;
            default: ld_data = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
            rsp   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: if (req_valid) state <= st_addr;  // busy strobes dropped
                st_addr: begin
                    if (req_q.we && awready) begin
                        state <= st_data;
                    end else if (!req_q.we && arready) begin
                        state <= st_resp;
                    end
                end
                st_data: if (wready) state <= st_resp;
                st_resp: begin
                    if (rsp_hs) begin
                        state     <= st_idle;
                        done      <= 1'b1;
                        rsp.rdata <= req_q.we ? 32'h0 : ld_data;
                        rsp.err   <= (bus_rsp.resp == resp_decerr);
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hw/mem_xbar.sv
module mem_xbar import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     arvalid,
    input  logic     awvalid,
    input  logic     wvalid,
    input  logic     rready,
    input  logic     bready,
    input  bus_req_t bus_req,
    output logic     arready,
    output logic     awready,
    output logic     wready,
    output logic     rvalid,
    output logic     bvalid,
    output bus_rsp_t bus_rsp,
    input  logic     sram_arready,
    input  logic     sram_awready,
    input  logic     sram_wready,
    input  logic     sram_rvalid,
    input  logic     sram_bvalid,
    input  bus_rsp_t sram_rsp,
    output logic     sram_arvalid,
    output logic     sram_awvalid,
    output logic     sram_wvalid,
    output logic     sram_rready,
    output logic     sram_bready,
    input  logic     ser_arready,
    input  logic     ser_awready,
    input  logic     ser_wready,
    input  logic     ser_rvalid,
    input  logic     ser_bvalid,
    input  bus_rsp_t ser_rsp,
    output logic     ser_arvalid,
    output logic     ser_awvalid,
    output logic     ser_wvalid,
    output logic     ser_rready,
    output logic     ser_bready
);

    logic sel_sram;
    logic sel_ser;
    logic sel_none;
    logic dec_pend;   // decode error owed to the core
    logic dec_write;  // pending error answers a write

    assign sel_sram  = (bus_req.addr >= sram_base) && (bus_req.addr < sram_limit);
    assign sel_ser   = (bus_req.addr == serial_addr);
    assign sel_none  = !sel_sram && !sel_ser;

    assign sram_arvalid = arvalid && sel_sram;
    assign sram_awvalid = awvalid && sel_sram;
    assign sram_wvalid  = wvalid && sel_sram;
    assign sram_rready  = rready && sel_sram;
    assign sram_bready  = bready && sel_sram;

    assign ser_arvalid = arvalid && sel_ser;
    assign ser_awvalid = awvalid && sel_ser;
    assign ser_wvalid  = wvalid && sel_ser;
    assign ser_rready  = rready && sel_ser;
    assign ser_bready  = bready && sel_ser;

    always_comb begin
        if (sel_sram) begin
            {arready, awready, wready} = {sram_arready, sram_awready, sram_wready};
            {rvalid, bvalid}           = {sram_rvalid, sram_bvalid};
            bus_rsp                    = sram_rsp;
        end else if (sel_ser) begin
            {arready, awready, wready} = {ser_arready, ser_awready, ser_wready};
            {rvalid, bvalid}           = {ser_rvalid, ser_bvalid};
            bus_rsp                    = ser_rsp;
        end else begin
            // unmapped, answered here
            {arready, awready, wready} = {3{!dec_pend}};
            rvalid                     = dec_pend && !dec_write;
            bvalid                     = dec_pend && dec_write;
            bus_rsp                    = '{rdata: 32'h0, resp: resp_decerr};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_pend  <= 1'b0;
            dec_write <= 1'b0;
        end else if (dec_pend) begin
            if ((rvalid && rready) || (bvalid && bready)) dec_pend <= 1'b0;
        end else if (sel_none && (arvalid || wvalid)) begin
            dec_pend  <= 1'b1;  // reads on ar, writes on w
            dec_write <= wvalid;
        end
    end

endmodule

//--- hw/sram_dev.sv
module sram_dev import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     arvalid,
    input  logic     awvalid,
    input  logic     wvalid,
    input  logic     rready,
    input  logic     bready,
    input  bus_req_t bus_req,
    output logic     arready,
    output logic     awready,
    output logic     wready,
    output logic     rvalid,
    output logic     bvalid,
    output bus_rsp_t bus_rsp
);

    logic [31:0]        mem [sram_words];
    logic [sram_aw-1:0] rd_idx;
    logic [sram_aw-1:0] wr_idx;
    logic [31:0]        rdata_q;
    logic               rd_wait;  // the one wait state
    logic               aw_seen;
    logic               ar_hs;
    logic               aw_hs;
    logic               w_hs;

    assign arready = !rd_wait && !rvalid;
    assign awready = !aw_seen && !bvalid;
    assign wready  = !bvalid;
    assign ar_hs   = arvalid && arready;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    assign bus_rsp = '{rdata: rdata_q, resp: resp_okay};

    always_ff @(posedge clk) begin
        if (ar_hs) rd_idx <= bus_req.addr[sram_aw+1:2];
        if (aw_hs) wr_idx <= bus_req.addr[sram_aw+1:2];
        if (rd_wait) rdata_q <= mem[rd_idx];
        if (w_hs) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_req.wstrb[i]) mem[wr_idx][i*8 +: 8] <= bus_req.wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wait <= 1'b0;
            rvalid  <= 1'b0;
            aw_seen <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            rd_wait <= ar_hs;
            if (rd_wait) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (aw_hs) begin
                aw_seen <= 1'b1;
            end else if (w_hs) begin
                aw_seen <= 1'b0;
            end
            if (w_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/serial_dev.sv
module serial_dev import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     arvalid,
    input  logic     awvalid,
    input  logic     wvalid,
    input  logic     rready,
    input  logic     bready,
    input  bus_req_t bus_req,
    output logic     arready,
    output logic     awready,
    output logic     wready,
    output logic     rvalid,
    output logic     bvalid,
    output bus_rsp_t bus_rsp,
    output logic [7:0] tx_byte,
    output logic     tx_valid
);

    logic [31:0] tx_count;
    logic [31:0] rdata_q;
    logic        aw_seen;
    logic        ar_hs;

    assign arready  = !rvalid;
    assign awready  = !aw_seen && !bvalid;
    assign wready   = !bvalid;
    assign ar_hs    = arvalid && arready;
    assign tx_valid = wvalid && wready;  // byte goes out on the data handshake
    assign bus_rsp  = '{rdata: rdata_q, resp: resp_okay};

    // lowest enabled lane
    always_comb begin
        casez (bus_req.wstrb)
            4'b???1: tx_byte = bus_req.wdata[7:0];
            4'b??10: tx_byte = bus_req.wdata[15:8];
            4'b?100: tx_byte = bus_req.wdata[23:16];
            default: tx_byte = bus_req.wdata[31:24];
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) rdata_q <= tx_count;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_count <= 32'h0;
            aw_seen  <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            if (tx_valid) tx_count <= tx_count + 32'd1;
            if (awvalid && awready) begin
                aw_seen <= 1'b1;
            end else if (tx_valid) begin
                aw_seen <= 1'b0;
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (tx_valid) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  lsu_req_t   req,
    output logic       done,
    output lsu_rsp_t   rsp,
    output logic [7:0] tx_byte,
    output logic       tx_valid
);

    // core to crossbar
    logic     arvalid, awvalid, wvalid, rready, bready;
    logic     arready, awready, wready, rvalid, bvalid;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    // crossbar to devices
    logic     sram_arvalid, sram_awvalid, sram_wvalid, sram_rready, sram_bready;
    logic     sram_arready, sram_awready, sram_wready, sram_rvalid, sram_bvalid;
    bus_rsp_t sram_rsp;
    logic     ser_arvalid, ser_awvalid, ser_wvalid, ser_rready, ser_bready;
    logic     ser_arready, ser_awready, ser_wready, ser_rvalid, ser_bvalid;
    bus_rsp_t ser_rsp;

    lsu_core core_i (.*);

    mem_xbar xbar_i (.*);

    sram_dev sram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (sram_arvalid),
        .awvalid (sram_awvalid),
        .wvalid  (sram_wvalid),
        .rready  (sram_rready),
        .bready  (sram_bready),
        .bus_req (bus_req),
        .arready (sram_arready),
        .awready (sram_awready),
        .wready  (sram_wready),
        .rvalid  (sram_rvalid),
        .bvalid  (sram_bvalid),
        .bus_rsp (sram_rsp)
    );

    serial_dev ser_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (ser_arvalid),
        .awvalid  (ser_awvalid),
        .wvalid   (ser_wvalid),
        .rready   (ser_rready),
        .bready   (ser_bready),
        .bus_req  (bus_req),
        .arready  (ser_arready),
        .awready  (ser_awready),
        .wready   (ser_wready),
        .rvalid   (ser_rvalid),
        .bvalid   (ser_bvalid),
        .bus_rsp  (ser_rsp),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid)
    );

endmodule

//--- verification/lsu_tb.sv
module lsu_tb import lsu_pkg::*; ();

    localparam int clk_period  = 100;
    localparam int drive_delay = 10;
    localparam int wait_limit  = 40;  // cycles per wait loop

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    lsu_req_t   req;
    logic       done;
    lsu_rsp_t   rsp;
    logic [7:0] tx_byte;
    logic       tx_valid;

    int         mismatches   = 0;
    int         timeouts     = 0;
    int         setup_errors = 0;
    int         tx_seen      = 0;  // tx_valid pulses from the DUT
    int         tx_expected  = 0;  // serial writes in the patterns so far
    logic [7:0] last_tx      = 8'h0;

    lsu_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // tx_valid is a single-cycle pulse, so one negedge per byte
    always @(negedge clk) begin
        if (rst_n && tx_valid) begin
            tx_seen = tx_seen + 1;
            last_tx = tx_byte;
        end
    end

    task automatic run_access(input logic we, input size_e size, input logic sign,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_rdata, input logic exp_err,
                              input logic tx_on, input logic [7:0] exp_tx);
        int   cycles;
        logic got;
        @(posedge clk);
        #drive_delay;
        req       = '{we: we, sign: sign, size: size, addr: addr, wdata: wdata};
        req_valid = 1'b1;
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b0;

        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < wait_limit) begin
            @(negedge clk);
            got = done;
            cycles++;
        end
        if (!got) begin
            $display("timeout at t=%0t: no done for access to %h", $time, addr);
            timeouts++;
        end else begin
            if (rsp.rdata !== exp_rdata) begin
                $display("FAIL t=%0t rsp.rdata exp %h got %h", $time, exp_rdata, rsp.rdata);
                mismatches++;
            end
            if (rsp.err !== exp_err) begin
                $display("FAIL t=%0t rsp.err exp %b got %b", $time, exp_err, rsp.err);
                mismatches++;
            end
        end

        if (tx_on) tx_expected++;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (tx_seen < tx_expected && cycles < wait_limit);
        if (tx_seen < tx_expected) begin
            $display("timeout at t=%0t: serial byte never sent for %h", $time, addr);
            timeouts++;
        end else if (tx_seen != tx_expected) begin
            $display("FAIL t=%0t tx_valid count exp %0d got %0d", $time, tx_expected, tx_seen);
            mismatches++;
        end else if (tx_on && last_tx !== exp_tx) begin
            $display("FAIL t=%0t tx_byte exp %h got %h", $time, exp_tx, last_tx);
            mismatches++;
        end
    endtask

    initial begin
        string       line;
        string       tx_str;
        int          fd;
        int          n;
        int          op;
        int          sz;
        int          sign;
        int          err;
        int          lines_run;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        tx_on;
        logic [7:0]  tx_val;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        lines_run = 0;
        repeat (3) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        fd = $fopen("verification/lsu_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;  // comments, blanks
                n = $sscanf(line, "%d %d %d %h %h %h %d %s",
                            op, sz, sign, addr, wdata, rdata, err, tx_str);
                if (n != 8) begin
                    $display("malformed pattern line: %s", line);
                    setup_errors++;
                    continue;
                end
                tx_on  = (tx_str != "none");
                tx_val = tx_on ? 8'(tx_str.atohex()) : 8'h0;
                // serial counter reads back the writes made so far
                if (op == 0 && addr == serial_addr) rdata = 32'(tx_expected);
                run_access(op[0], size_e'(sz[1:0]), sign[0], addr, wdata, rdata,
                           err[0], tx_on, tx_val);
                lines_run++;
            end
            $fclose(fd);
            if (lines_run == 0) begin
                $display("pattern file held no accesses");
                setup_errors++;
            end
        end

        repeat (2) @(posedge clk);
        $display("%0d accesses, errors: %0d mismatches, %0d timeouts, %0d setup",
                 lines_run, mismatches, timeouts, setup_errors);
        if (mismatches + timeouts + setup_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verification/lsu_patterns.txt
# op(0 load,1 store) size(1 byte,2 half,3 word) sign addr wdata exp_rdata exp_err exp_tx(hex or none)
# store wdata is unshifted; serial loads expect the count of serial writes so far
1 3 0 80000010 12345678 00000000 0 none
0 3 0 80000010 00000000 12345678 0 none
1 1 0 80000011 000000aa 00000000 0 none
1 2 0 80000012 0000beef 00000000 0 none
0 3 0 80000010 00000000 beefaa78 0 none
0 1 1 80000011 00000000 ffffffaa 0 none
0 1 0 80000011 00000000 000000aa 0 none
0 1 1 80000010 00000000 00000078 0 none
0 1 1 80000012 00000000 ffffffef 0 none
0 1 0 80000013 00000000 000000be 0 none
0 2 1 80000012 00000000 ffffbeef 0 none
0 2 0 80000010 00000000 0000aa78 0 none
1 1 0 80000010 000000c3 00000000 0 none
1 1 0 80000013 0000005a 00000000 0 none
1 1 0 80000012 00000066 00000000 0 none
1 2 0 80000010 00001357 00000000 0 none
0 3 0 80000010 00000000 5a661357 0 none
0 2 1 80000012 00000000 00005a66 0 none
1 1 0 a00003f8 00000041 00000000 0 41
1 3 0 a00003f8 12345642 00000000 0 42
0 3 0 a00003f8 00000000 00000002 0 none
1 3 0 80000000 0badf00d 00000000 0 none
1 3 0 80000400 deadbeef 00000000 1 none
0 3 0 00001000 00000000 00000000 1 none
1 1 0 a00003fc 00000099 00000000 1 none
0 3 0 80000000 00000000 0badf00d 0 none
0 3 0 a00003f8 00000000 00000002 0 none

//--- list.f
common/lsu_pkg.sv
lsu/lsu_core.sv
hw/mem_xbar.sv
hw/sram_dev.sv
hw/serial_dev.sv
hw/lsu_top.sv
verification/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - lsu/lsu_core.sv
  - hw/mem_xbar.sv
  - hw/sram_dev.sv
  - hw/serial_dev.sv
  - hw/lsu_top.sv
  - target: simulation
    files:
      - verification/lsu_tb.sv
